//--- design/rx_const_pkg.sv
`default_nettype none

// Word geometry shared by every stage of the receive datapath.
package rx_const_pkg;

    localparam int CHANNEL_WIDTH  = 4;    // Lanes delivered by the ADC per word.
    localparam int CODE_PRECISION = 8;    // Signed ADC code width.

    // Width of the word offset used by the output aligners.
    localparam int ALIGN_WIDTH = $clog2(CHANNEL_WIDTH);

    typedef logic signed [CODE_PRECISION-1:0] code_t;

    // Lane 0 sits at index 0 and is the earliest sample of the word.
    typedef code_t [CHANNEL_WIDTH-1:0] code_word_t;

endpackage : rx_const_pkg

`default_nettype wire

//--- design/ffe_cmp_pkg.sv
`default_nettype none

// Equalizer and slicer arithmetic widths and result types.
package ffe_cmp_pkg;

    // FFE_LENGTH may not exceed CHANNEL_WIDTH+1, since taps reach back one word only.
    localparam int FFE_LENGTH       = 3;
    localparam int WEIGHT_PRECISION = 6;
    localparam int SHIFT_PRECISION  = 3;
    localparam int OUTPUT_PRECISION = 10;
    localparam int ACC_PRECISION    = 18;   // Holds FFE_LENGTH full-scale products.
    localparam int NUM_LEVELS       = 3;    // PAM4 needs three decision levels.

    typedef logic signed [WEIGHT_PRECISION-1:0] weight_t;
    typedef logic        [SHIFT_PRECISION-1:0]  shift_t;  // Right shift amount.
    typedef logic signed [OUTPUT_PRECISION-1:0] est_t;
    typedef logic        [NUM_LEVELS-1:0]       sym_t;    // Thermometer code.

    // Saturation limits of an estimate.
    localparam est_t EST_MAX = {1'b0, {(OUTPUT_PRECISION-1){1'b1}}};
    localparam est_t EST_MIN = {1'b1, {(OUTPUT_PRECISION-1){1'b0}}};

    typedef est_t [rx_const_pkg::CHANNEL_WIDTH-1:0] est_word_t;
    typedef sym_t [rx_const_pkg::CHANNEL_WIDTH-1:0] sym_word_t;

    // Indexed as [tap][lane].
    typedef weight_t [FFE_LENGTH-1:0][rx_const_pkg::CHANNEL_WIDTH-1:0] weight_array_t;
    typedef shift_t [rx_const_pkg::CHANNEL_WIDTH-1:0] shift_array_t;
    typedef est_t [NUM_LEVELS-1:0] level_array_t;

endpackage : ffe_cmp_pkg

`default_nettype wire

//--- design/slice_if.sv
`default_nettype none
`timescale 1ns/1ps

// Carries one sliced word. Contents are only meaningful while valid is high.
interface slice_if import rx_const_pkg::*, ffe_cmp_pkg::*; ();

    logic       valid;
    est_word_t  est;
    sym_word_t  sym;
    code_word_t codes;    // Raw codes kept in step with the estimates.

    modport src (
        output valid, est, sym, codes
    );

    modport dst (
        input valid, est, sym, codes
    );

endinterface : slice_if

`default_nettype wire

//--- design/code_history.sv
`default_nettype none
`timescale 1ns/1ps

module code_history import rx_const_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n_i,

    input  wire logic       valid_i,
    input  wire code_word_t codes_i,

    output logic            hist_valid_o,
    output code_word_t      cur_o,
    output code_word_t      prev_o
);

    // The FFE taps reach into the word before the current one, so the
    // previous valid word is kept next to the current one.
    // Both words only move on a strobe; idle cycles leave the history alone.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_valid_o <= 1'b0;
            cur_o        <= '0;
            prev_o       <= '0;   // Samples before the first word read as zero.
        end else begin
            hist_valid_o <= valid_i;
            if (valid_i) begin
                prev_o <= cur_o;
                cur_o  <= codes_i;
            end
        end
    end

endmodule : code_history

`default_nettype wire

//--- design/ffe_filter.sv
`default_nettype none
`timescale 1ns/1ps

module ffe_filter import rx_const_pkg::*, ffe_cmp_pkg::*; (
    input  wire logic          clk,
    input  wire logic          arst_n_i,

    input  wire logic          hist_valid_i,
    input  wire code_word_t    cur_i,
    input  wire code_word_t    prev_i,

    input  wire weight_array_t weights_i,
    input  wire shift_array_t  shift_i,

    output logic               est_valid_o,
    output est_word_t          est_o,
    output code_word_t         codes_o
);

    code_t [2*CHANNEL_WIDTH-1:0] samples;   // Previous word low, current word high.
    est_word_t                   est_next;

    assign samples = {cur_i, prev_i};

    always_comb begin
        logic signed [ACC_PRECISION-1:0] acc;
        logic signed [ACC_PRECISION-1:0] shifted;
        code_t                           sample;
        weight_t                         weight;

        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            acc = '0;
            // Tap t of a lane sees the sample t positions earlier in time.
            for (int tap = 0; tap < FFE_LENGTH; tap++) begin
                sample = samples[CHANNEL_WIDTH + lane - tap];
                weight = weights_i[tap][lane];
                acc    = acc + sample * weight;
            end

            shifted = acc >>> shift_i[lane];

            if (shifted > EST_MAX) begin
                est_next[lane] = EST_MAX;
            end else if (shifted < EST_MIN) begin
                est_next[lane] = EST_MIN;
            end else begin
                est_next[lane] = est_t'(shifted);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            est_valid_o <= 1'b0;
        end else begin
            est_valid_o <= hist_valid_i;
        end
    end

    // Codes travel with their estimates so the output can report both.
    always_ff @(posedge clk) begin
        if (hist_valid_i) begin
            est_o   <= est_next;
            codes_o <= cur_i;
        end
    end

endmodule : ffe_filter

`default_nettype wire

//--- design/pam4_slicer.sv
`default_nettype none
`timescale 1ns/1ps

module pam4_slicer import rx_const_pkg::*, ffe_cmp_pkg::*; (
    input  wire logic         clk,
    input  wire logic         arst_n_i,

    input  wire logic         est_valid_i,
    input  wire est_word_t    est_i,
    input  wire code_word_t   codes_i,

    input  wire level_array_t levels_i,

    slice_if.src              slice
);

    sym_word_t sym_next;

    // Bit j is set when the estimate lies strictly above level j. With
    // ascending levels this gives a thermometer code.
    always_comb begin
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            for (int lvl = 0; lvl < NUM_LEVELS; lvl++) begin
                sym_next[lane][lvl] = est_i[lane] > levels_i[lvl];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slice.valid <= 1'b0;
        end else begin
            slice.valid <= est_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (est_valid_i) begin
            slice.sym   <= sym_next;
            slice.est   <= est_i;
            slice.codes <= codes_i;
        end
    end

endmodule : pam4_slicer

`default_nettype wire

//--- design/window_aligner.sv
`default_nettype none
`timescale 1ns/1ps

module window_aligner import rx_const_pkg::*; #(
    parameter type payload_t = logic
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,

    input  wire logic                     valid_i,
    input  wire payload_t [CHANNEL_WIDTH-1:0] word_i,
    input  wire logic [ALIGN_WIDTH-1:0]   align_pos_i,

    output payload_t [CHANNEL_WIDTH-1:0]  word_o
);

    payload_t [CHANNEL_WIDTH-1:0]   prev_word;
    payload_t [2*CHANNEL_WIDTH-1:0] segment;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_word <= '0;
        end else if (valid_i) begin
            prev_word <= word_i;
        end
    end

    assign segment = {word_i, prev_word};

    // The window starts align_pos entries into the previous word.
    always_comb begin
        for (int c = 0; c < CHANNEL_WIDTH; c++) begin
            word_o[c] = segment[int'(align_pos_i) + c];
        end
    end

endmodule : window_aligner

`default_nettype wire

//--- design/rx_output_stage.sv
`default_nettype none
`timescale 1ns/1ps

module rx_output_stage import rx_const_pkg::*, ffe_cmp_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,

    slice_if.dst                        slice,
    input  wire logic [ALIGN_WIDTH-1:0] align_pos_i,

    output logic                        valid_o,
    output est_word_t                   est_o,
    output code_word_t                  codes_o,
    output sym_word_t                   sym_aligned_o,
    output est_word_t                   est_aligned_o
);

    sym_word_t sym_window;
    est_word_t est_window;

    window_aligner #(
        .payload_t   (sym_t)
    ) sym_aligner (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (slice.valid),
        .word_i      (slice.sym),
        .align_pos_i (align_pos_i),
        .word_o      (sym_window)
    );

    window_aligner #(
        .payload_t   (est_t)
    ) est_aligner (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (slice.valid),
        .word_i      (slice.est),
        .align_pos_i (align_pos_i),
        .word_o      (est_window)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= slice.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (slice.valid) begin
            est_o         <= slice.est;     // Unaligned, in ADC lane order.
            codes_o       <= slice.codes;
            sym_aligned_o <= sym_window;
            est_aligned_o <= est_window;
        end
    end

endmodule : rx_output_stage

`default_nettype wire

//--- design/bits_estimator_datapath.sv
`default_nettype none
`timescale 1ns/1ps

module bits_estimator_datapath import rx_const_pkg::*, ffe_cmp_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,

    input  wire logic                   valid_i,
    input  wire code_word_t             act_codes_i,

    // Quasi-static settings. They only change while no word is in flight.
    input  wire weight_array_t          weights_i,
    input  wire shift_array_t           ffe_shift_i,
    input  wire level_array_t           slice_levels_i,
    input  wire logic [ALIGN_WIDTH-1:0] align_pos_i,

    output logic                        valid_o,
    output est_word_t                   est_syms_o,
    output code_word_t                  act_codes_o,
    output sym_word_t                   symbols_o,
    output est_word_t                   aligned_est_syms_o
);

    logic       hist_valid;
    code_word_t cur_codes;
    code_word_t prev_codes;

    logic       est_valid;
    est_word_t  est_word;
    code_word_t est_codes;

    slice_if slice_bus ();

    code_history u_code_history (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .codes_i      (act_codes_i),
        .hist_valid_o (hist_valid),
        .cur_o        (cur_codes),
        .prev_o       (prev_codes)
    );

    ffe_filter u_ffe_filter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hist_valid_i (hist_valid),
        .cur_i        (cur_codes),
        .prev_i       (prev_codes),
        .weights_i    (weights_i),
        .shift_i      (ffe_shift_i),
        .est_valid_o  (est_valid),
        .est_o        (est_word),
        .codes_o      (est_codes)
    );

    pam4_slicer u_pam4_slicer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .est_valid_i  (est_valid),
        .est_i        (est_word),
        .codes_i      (est_codes),
        .levels_i     (slice_levels_i),
        .slice        (slice_bus)
    );

    // Fourth register stage. valid_o follows valid_i by four cycles.
    rx_output_stage u_rx_output_stage (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .slice         (slice_bus),
        .align_pos_i   (align_pos_i),
        .valid_o       (valid_o),
        .est_o         (est_syms_o),
        .codes_o       (act_codes_o),
        .sym_aligned_o (symbols_o),
        .est_aligned_o (aligned_est_syms_o)
    );

endmodule : bits_estimator_datapath

`default_nettype wire

//--- verif/bits_estimator_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module bits_estimator_assertions import rx_const_pkg::*, ffe_cmp_pkg::*; (
    input  wire logic         clk,
    input  wire logic         arst_n_i,
    input  wire logic         valid_in_i,
    input  wire logic         valid_out_i,
    input  wire sym_word_t    symbols_i,
    input  wire level_array_t levels_i
);

    int unsigned fail_count = 0;   // Read by the testbench at the end of the run.

    function automatic logic levels_ascending(input level_array_t lv);
        logic asc;
        asc = 1'b1;
        for (int j = 1; j < NUM_LEVELS; j++) begin
            if (!(lv[j] > lv[j-1])) begin
                asc = 1'b0;
            end
        end
        return asc;
    endfunction

    // A thermometer symbol plus one is a power of two.
    function automatic logic word_is_thermometer(input sym_word_t w);
        sym_t s;
        sym_t s_inc;
        logic ok;
        ok = 1'b1;
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            s     = w[lane];
            s_inc = s + 1'b1;
            if ((s_inc & s) != '0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    a_valid_latency : assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_out_i == $past(valid_in_i, 4))
        else begin
            $error("valid_o does not follow valid_i by four cycles");
            fail_count++;
        end

    a_valid_after_reset : assert property (@(posedge clk) $rose(arst_n_i) |-> !valid_out_i)
        else begin
            $error("valid_o is high right after reset");
            fail_count++;
        end

    a_thermometer : assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_out_i && levels_ascending(levels_i)) |-> word_is_thermometer(symbols_i))
        else begin
            $error("symbols_o holds a lane that is not a thermometer code");
            fail_count++;
        end

endmodule : bits_estimator_assertions

bind bits_estimator_datapath bits_estimator_assertions u_assertions (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_in_i  (valid_i),
    .valid_out_i (valid_o),
    .symbols_i   (symbols_o),
    .levels_i    (slice_levels_i)
);

`default_nettype wire

//--- verif/tb_bits_estimator.sv
`default_nettype none
`timescale 1ns/1ps

module tb_bits_estimator import rx_const_pkg::*, ffe_cmp_pkg::*; ();

    localparam int BURST_WORDS = 10;
    localparam int NUM_BURSTS  = 16;
    localparam int MAX_GAP     = 4;
    localparam int LATENCY     = 4;
    // Each burst counted with every gap at its maximum plus the drain.
    localparam int STIM_CYCLES    = 2 + NUM_BURSTS * (BURST_WORDS * (MAX_GAP + 1) + LATENCY + 4);
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

    typedef struct packed {
        int         due;      // Cycle count at which valid_o must be seen.
        code_word_t codes;
        est_word_t  est;
        sym_word_t  sym;
        sym_word_t  sym_al;
        est_word_t  est_al;
    } exp_word_t;

    logic                   clk;
    logic                   arst_n_i;
    logic                   valid_i;
    code_word_t             act_codes_i;
    weight_array_t          weights;
    shift_array_t           shifts;
    level_array_t           levels;
    logic [ALIGN_WIDTH-1:0] align_pos;
    logic                   valid_o;
    est_word_t              est_syms_o;
    code_word_t             act_codes_o;
    sym_word_t              symbols_o;
    est_word_t              aligned_est_syms_o;

    code_t     sample_hist [$];   // Every accepted code in arrival order.
    exp_word_t exp_q [$];
    est_word_t last_est = '0;
    sym_word_t last_sym = '0;
    int        cycle_cnt = 0;
    int        value_errors = 0;
    int        protocol_errors = 0;

    bits_estimator_datapath UUT (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .valid_i            (valid_i),
        .act_codes_i        (act_codes_i),
        .weights_i          (weights),
        .ffe_shift_i        (shifts),
        .slice_levels_i     (levels),
        .align_pos_i        (align_pos),
        .valid_o            (valid_o),
        .est_syms_o         (est_syms_o),
        .act_codes_o        (act_codes_o),
        .symbols_o          (symbols_o),
        .aligned_est_syms_o (aligned_est_syms_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped at cycle %0d with %0d words still pending",
                     cycle_cnt, exp_q.size());
            $display("Errors: %0d value, %0d protocol, %0d assertion",
                     value_errors, protocol_errors, UUT.u_assertions.fail_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_code(input string name, input code_t exp, input code_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_est(input string name, input est_t exp, input est_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_sym(input string name, input sym_t exp, input sym_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // Expected result of the newest word, whose codes are already in sample_hist.
    function automatic exp_word_t expected_word(input code_word_t codes);
        exp_word_t e;
        int        base;
        int        acc;
        int        idx;
        int        pos;
        int        est_max;
        base    = sample_hist.size() - CHANNEL_WIDTH;
        est_max = (1 << (OUTPUT_PRECISION - 1)) - 1;
        e       = '0;
        e.codes = codes;
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            acc = 0;
            for (int t = 0; t < FFE_LENGTH; t++) begin
                idx = base + lane - t;
                if (idx >= 0) begin
                    acc += int'(sample_hist[idx]) * int'(weights[t][lane]);
                end
            end
            acc = acc >>> shifts[lane];
            acc = (acc > est_max) ? est_max : (acc < -est_max - 1) ? -est_max - 1 : acc;
            e.est[lane] = est_t'(acc);
            for (int j = 0; j < NUM_LEVELS; j++) begin
                e.sym[lane][j] = e.est[lane] > levels[j];
            end
        end
        for (int c = 0; c < CHANNEL_WIDTH; c++) begin
            pos = int'(align_pos) + c;
            e.sym_al[c] = (pos < CHANNEL_WIDTH) ? last_sym[pos] : e.sym[pos - CHANNEL_WIDTH];
            e.est_al[c] = (pos < CHANNEL_WIDTH) ? last_est[pos] : e.est[pos - CHANNEL_WIDTH];
        end
        return e;
    endfunction

    always @(negedge clk) begin : compare_outputs
        exp_word_t e;
        if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
            e = exp_q.pop_front();
            check_valid("valid_o", 1'b1, valid_o);
            for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
                check_code($sformatf("act_codes_o[%0d]", lane), e.codes[lane], act_codes_o[lane]);
                check_est($sformatf("est_syms_o[%0d]", lane), e.est[lane], est_syms_o[lane]);
                check_sym($sformatf("symbols_o[%0d]", lane), e.sym_al[lane], symbols_o[lane]);
                check_est($sformatf("aligned_est_syms_o[%0d]", lane), e.est_al[lane],
                          aligned_est_syms_o[lane]);
            end
        end else if (valid_o === 1'b1 && exp_q.size() == 0) begin
            $display("ERROR at %0t: valid_o is high but no word was sent", $time);
            protocol_errors++;
        end else if (arst_n_i === 1'b1) begin
            check_valid("valid_o", 1'b0, valid_o);
        end
    end

    // Mode 0 gives random codes, 1 codes on or next to a level, 2 full-scale words.
    function automatic code_word_t make_codes(input int mode);
        code_word_t w;
        logic       neg;
        int         near;
        neg = 1'(($urandom_range(1, 0)));
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            near = int'(levels[$urandom_range(NUM_LEVELS - 1, 0)]) + int'($urandom_range(2, 0)) - 1;
            w[lane] = code_t'($urandom);
            if (mode == 1 && $urandom_range(1, 0) == 1) begin
                w[lane] = code_t'(near);
            end else if (mode == 2) begin
                w[lane] = neg ? code_t'(-128) : code_t'(127);
            end
        end
        return w;
    endfunction

    task automatic apply_word(input code_word_t w);
        exp_word_t e;
        @(negedge clk);
        valid_i     = 1'b1;
        act_codes_i = w;
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            sample_hist.push_back(w[lane]);
        end
        e     = expected_word(w);
        e.due = cycle_cnt + LATENCY;
        exp_q.push_back(e);
        last_est = e.est;
        last_sym = e.sym;
    endtask

    // Sends one burst and returns once every word has come out.
    task automatic run_burst(input int mode, input int max_gap);
        int gap;
        for (int n = 0; n < BURST_WORDS; n++) begin
            apply_word(make_codes(mode));
            gap = $urandom_range(max_gap, 0);
            repeat (gap) begin
                @(negedge clk);
                valid_i     = 1'b0;
                act_codes_i = make_codes(0);   // Idle codes must stay out of the history.
            end
        end
        @(negedge clk);
        valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic set_identity();
        weights = '0;
        shifts  = '0;
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            weights[0][lane] = weight_t'(1);
        end
    endtask

    task automatic set_ffe(input int kind);
        for (int t = 0; t < FFE_LENGTH; t++) begin
            for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
                weights[t][lane] = weight_t'($urandom);
                if (kind == 1) begin
                    weights[t][lane] = weight_t'(31);
                end else if (kind == 2) begin
                    weights[t][lane] = ($urandom_range(1, 0) == 1) ? weight_t'(31) : weight_t'(-32);
                end
            end
        end
        for (int lane = 0; lane < CHANNEL_WIDTH; lane++) begin
            shifts[lane] = (kind == 0) ? shift_t'($urandom) : '0;
        end
    endtask

    task automatic pick_levels(input int span);
        int lvl;
        lvl = -span;
        for (int j = 0; j < NUM_LEVELS; j++) begin
            lvl = lvl + int'($urandom_range(span, 1));
            levels[j] = est_t'(lvl);
        end
    endtask

    initial begin : stimulus
        void'($urandom(32'h3c8a_fa8e));
        arst_n_i    = 1'b0;
        valid_i     = 1'b0;
        act_codes_i = '0;
        align_pos   = '0;
        set_identity();
        pick_levels(100);
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;

        run_burst(0, 0);
        for (int b = 0; b < 4; b++) begin
            set_ffe(0);
            pick_levels(150);
            align_pos = ALIGN_WIDTH'($urandom);
            run_burst(0, 0);
        end
        for (int b = 0; b < 3; b++) begin
            set_ffe(0);
            run_burst(0, MAX_GAP);
        end
        set_identity();   // Estimates equal the codes, so levels are hit exactly.
        for (int b = 0; b < 2; b++) begin
            pick_levels(40);
            run_burst(1, 1);
        end
        for (int p = 0; p < CHANNEL_WIDTH; p++) begin
            set_ffe(0);
            align_pos = ALIGN_WIDTH'(p);
            run_burst(0, 0);
        end
        for (int b = 1; b <= 2; b++) begin
            set_ffe(b);
            run_burst(2, 0);
        end

        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, UUT.u_assertions.fail_count);
        if (value_errors == 0 && protocol_errors == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_bits_estimator

`default_nettype wire

//--- project.f
design/rx_const_pkg.sv
design/ffe_cmp_pkg.sv
design/slice_if.sv
design/code_history.sv
design/ffe_filter.sv
design/pam4_slicer.sv
design/window_aligner.sv
design/rx_output_stage.sv
design/bits_estimator_datapath.sv
verif/bits_estimator_assertions.sv
verif/tb_bits_estimator.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail

LOG=sim.log

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_bits_estimator \
        -f project.f -Mdir obj_dir -o tb_bits_estimator \
    && ./obj_dir/tb_bits_estimator 2>&1 | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Test FAILED" "$LOG" && exit 1 || exit 0
